// ==== src/wallace_pkg.sv ====
package wallace_pkg;

  localparam int OPERAND_W = 16;
  localparam int PRODUCT_W = 2 * OPERAND_W;
  // register stages from operands to product
  localparam int LATENCY = 4;

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PRODUCT_W-1:0] product_t;

  typedef struct packed {
    operand_t a;
    operand_t b;
  } operands_t;

  // the two rows left after carry-save reduction
  typedef struct packed {
    product_t sum;
    product_t carry;
  } csa_pair_t;

  ////////////////////////////////////////////////////////////////////////////
  // row bookkeeping for the 3:2 layers
  ////////////////////////////////////////////////////////////////////////////

  // each full group of three becomes two rows and leftovers pass
  function automatic int csa_rows_out(int rows_in);
    return 2 * (rows_in / 3) + rows_in % 3;
  endfunction

  function automatic int csa_rows_after(int rows_in, int layers);
    int n;
    n = rows_in;
    for (int k = 0; k < layers; k++) begin
      n = csa_rows_out(n);
    end
    return n;
  endfunction

  // layers needed to get down to rows_out but never below two rows
  function automatic int csa_depth(int rows_in, int rows_out);
    int n;
    int d;
    n = rows_in;
    d = 0;
    while (n > rows_out && n > 2) begin
      n = csa_rows_out(n);
      d++;
    end
    return d;
  endfunction

endpackage

// ==== src/partial_product_gen.sv ====
`timescale 1ns/1ps

module partial_product_gen (
  input  logic                                                clk,
  input  logic                                                arst_n,
  input  wallace_pkg::operands_t                              ops,
  output wallace_pkg::product_t [wallace_pkg::OPERAND_W-1:0] rows
);

  wallace_pkg::product_t [wallace_pkg::OPERAND_W-1:0] rows_d;

  ////////////////////////////////////////////////////////////////////////////
  // AND matrix
  ////////////////////////////////////////////////////////////////////////////

  // row i is a gated by b[i] and moved up to column weight i
  always_comb begin
    for (int i = 0; i < wallace_pkg::OPERAND_W; i++) begin
      rows_d[i] = wallace_pkg::product_t'(ops.a & {wallace_pkg::OPERAND_W{ops.b[i]}}) << i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rows <= '0;
    end else begin
      rows <= rows_d;
    end
  end

endmodule

// ==== src/csa_layer.sv ====
`timescale 1ns/1ps

// one purely combinational Wallace layer
module csa_layer #(
  parameter int rows_in = 3
) (
  input  wallace_pkg::product_t [rows_in-1:0]                           rows,
  output wallace_pkg::product_t [wallace_pkg::csa_rows_out(rows_in)-1:0] reduced
);

  localparam int groups   = rows_in / 3;
  localparam int w        = wallace_pkg::PRODUCT_W;

  ////////////////////////////////////////////////////////////////////////////
  // 3:2 compression per group
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < groups; g++) begin : g_grp
    wallace_pkg::product_t x;
    wallace_pkg::product_t y;
    wallace_pkg::product_t z;
    wallace_pkg::product_t cy;

    assign x = rows[3*g];
    assign y = rows[3*g+1];
    assign z = rows[3*g+2];

    // column sum bits
    assign reduced[2*g] = x ^ y ^ z;

    // full adder carry that acts as a half adder wherever z has no bit
    assign cy = (x & y) | (z & (x ^ y));

    // carries weigh one column more and the bit 31 carry falls off
    assign reduced[2*g+1] = {cy[w-2:0], 1'b0};
  end

  ////////////////////////////////////////////////////////////////////////////
  // leftover rows
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 3 * groups; r < rows_in; r++) begin : g_pass
    // lands after the 2*groups compressed rows
    assign reduced[r-groups] = rows[r];
  end

endmodule

// ==== src/csa_reduce_stage.sv ====
`timescale 1ns/1ps

module csa_reduce_stage #(
  parameter int rows_in  = 16,
  parameter int rows_out = 6
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  wallace_pkg::product_t [rows_in-1:0]   rows,
  output wallace_pkg::product_t [rows_out-1:0]  reduced
);

  localparam int depth = wallace_pkg::csa_depth(rows_in, rows_out);

  wallace_pkg::product_t [rows_out-1:0] chain_out;

  // the chain must land on rows_out exactly
  if (depth < 1 || wallace_pkg::csa_rows_after(rows_in, depth) != rows_out) begin : g_bad_target
    $error("csa_reduce_stage: %0d rows do not reduce to exactly %0d", rows_in, rows_out);
  end

  ////////////////////////////////////////////////////////////////////////////
  // layer chain
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < depth; i++) begin : g_layer
    localparam int n_in  = wallace_pkg::csa_rows_after(rows_in, i);
    localparam int n_out = wallace_pkg::csa_rows_out(n_in);

    wallace_pkg::product_t [n_out-1:0] layer_out;

    if (i == 0) begin : g_first
      csa_layer #(
        .rows_in (n_in)
      ) u_layer (
        .rows    (rows),
        .reduced (layer_out)
      );
    end else begin : g_next
      csa_layer #(
        .rows_in (n_in)
      ) u_layer (
        .rows    (g_layer[i-1].layer_out),
        .reduced (layer_out)
      );
    end
  end

  assign chain_out = g_layer[depth-1].layer_out;

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reduced <= '0;
    end else begin
      reduced <= chain_out;
    end
  end

endmodule

// ==== src/final_adder_stage.sv ====
`timescale 1ns/1ps

module final_adder_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  wallace_pkg::csa_pair_t pair,
  output wallace_pkg::product_t  product
);

  wallace_pkg::product_t sum_d;

  ////////////////////////////////////////////////////////////////////////////
  // ripple carry-propagate adder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : ripple
    logic cy;
    cy = 1'b0;
    for (int i = 0; i < wallace_pkg::PRODUCT_W; i++) begin
      sum_d[i] = pair.sum[i] ^ pair.carry[i] ^ cy;
      cy       = (pair.sum[i] & pair.carry[i]) | (cy & (pair.sum[i] ^ pair.carry[i]));
    end
    // carry out of bit 31 is dropped since the product always fits
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      product <= '0;
    end else begin
      product <= sum_d;
    end
  end

endmodule

// ==== src/wallace_mul_top.sv ====
`timescale 1ns/1ps

// 16x16 unsigned Wallace multiplier with four register stages
module wallace_mul_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  wallace_pkg::operands_t ops,
  output wallace_pkg::product_t  product
);

  // 16 -> 6 in the first reduction stage and 6 -> 2 in the second
  localparam int pp_rows  = wallace_pkg::OPERAND_W;
  localparam int mid_rows = 6;
  localparam int end_rows = 2;

  wallace_pkg::product_t [pp_rows-1:0]  pp_rows_q;
  wallace_pkg::product_t [mid_rows-1:0] mid_rows_q;
  wallace_pkg::product_t [end_rows-1:0] end_rows_q;
  wallace_pkg::csa_pair_t               pair;

  partial_product_gen u_ppg (
    .clk    (clk),
    .arst_n (arst_n),
    .ops    (ops),
    .rows   (pp_rows_q)
  );

  csa_reduce_stage #(
    .rows_in  (pp_rows),
    .rows_out (mid_rows)
  ) u_reduce0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .rows    (pp_rows_q),
    .reduced (mid_rows_q)
  );

  csa_reduce_stage #(
    .rows_in  (mid_rows),
    .rows_out (end_rows)
  ) u_reduce1 (
    .clk     (clk),
    .arst_n  (arst_n),
    .rows    (mid_rows_q),
    .reduced (end_rows_q)
  );

  assign pair.sum   = end_rows_q[0];
  assign pair.carry = end_rows_q[1];

  final_adder_stage u_cpa (
    .clk     (clk),
    .arst_n  (arst_n),
    .pair    (pair),
    .product (product)
  );

endmodule

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
  parameter int period_ns = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

// ==== test/wallace_mul_sva.sv ====
`timescale 1ns/1ps

module wallace_mul_sva (
  input logic                   clk,
  input logic                   arst_n,
  input wallace_pkg::operands_t ops,
  input wallace_pkg::product_t  product
);

  wallace_pkg::product_t expect_p;
  logic [2:0]            settle_cnt;

  assign expect_p = wallace_pkg::product_t'(ops.a) * wallace_pkg::product_t'(ops.b);

  // counts edges since reset release up to the pipeline depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      settle_cnt <= '0;
    end else if (settle_cnt < 3'(wallace_pkg::LATENCY)) begin
      settle_cnt <= settle_cnt + 3'd1;
    end
  end

  a_zero_in_reset: assert property (@(posedge clk) !arst_n |-> product == '0)
    else $error("product is %h while arst_n is low", product);

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    settle_cnt == 3'(wallace_pkg::LATENCY) |-> product == $past(expect_p, wallace_pkg::LATENCY))
    else $error("product %h does not match the operands four edges back", product);

  a_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(product))
    else $error("product has unknown bits");

endmodule

// ==== test/tb_wallace_mul.sv ====
`timescale 1ns/1ps

module tb_wallace_mul;

  localparam int reset_cycles     = 5;
  localparam int rand_count       = 200;
  localparam int rand_reset_at    = 120;
  localparam int mid_reset_cycles = 3;
  localparam int latency          = wallace_pkg::LATENCY;

  logic                   clk;
  logic                   arst_n;
  wallace_pkg::operands_t ops;
  wallace_pkg::product_t  product;

  // expected products, oldest at the front
  wallace_pkg::product_t  sb[$];
  wallace_pkg::operand_t  vec_a[$];
  wallace_pkg::operand_t  vec_b[$];
  wallace_pkg::product_t  vec_p[$];
  int                     cycles = 0;
  int                     timeout_limit;
  int                     checks;
  logic [31:0]            rng;

  clk_gen #(
    .period_ns (20)
  ) u_clk (
    .clk (clk)
  );

  wallace_mul_top dut0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .ops     (ops),
    .product (product)
  );

  bind wallace_mul_top wallace_mul_sva u_sva (
    .clk     (clk),
    .arst_n  (arst_n),
    .ops     (ops),
    .product (product)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic wallace_pkg::product_t wide_mul(input wallace_pkg::operand_t a,
                                                     input wallace_pkg::operand_t b);
    return wallace_pkg::product_t'(a) * wallace_pkg::product_t'(b);
  endfunction

  task automatic stop_on_fail();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_product(input wallace_pkg::product_t exp);
    assert (product === exp) else begin
      $display("ERR product: got %h, expected %h", product, exp);
      stop_on_fail();
    end
    checks++;
  endtask

  task automatic read_vectors();
    int                    fd;
    int                    n;
    string                 line;
    wallace_pkg::operand_t va;
    wallace_pkg::operand_t vb;
    wallace_pkg::product_t vp;
    fd = $fopen("test/mul_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open test/mul_vectors.txt");
      stop_on_fail();
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // comment lines fail the scan and are skipped
        if (n > 0 && $sscanf(line, "%h %h %h", va, vb, vp) == 3) begin
          assert (vp === wide_mul(va, vb)) else begin
            $display("ERR vector file product for %h x %h: listed %h, a*b is %h",
                     va, vb, vp, wide_mul(va, vb));
            stop_on_fail();
          end
          vec_a.push_back(va);
          vec_b.push_back(vb);
          vec_p.push_back(vp);
        end
      end
      $fclose(fd);
      if (vec_a.size() == 0) begin
        $display("no operand pairs found in test/mul_vectors.txt");
        stop_on_fail();
      end
    end
  endtask

  // on each falling edge check the oldest product and then drive the next pair
  task automatic drive_and_check(input wallace_pkg::operand_t a,
                                 input wallace_pkg::operand_t b,
                                 input wallace_pkg::product_t exp);
    @(negedge clk);
    if (sb.size() == latency) begin
      check_product(sb.pop_front());
    end
    ops.a = a;
    ops.b = b;
    sb.push_back(exp);
  endtask

  task automatic hold_reset(input int n_cycles);
    arst_n = 1'b0;
    sb.delete();
    #1;
    check_product('0);
    repeat (n_cycles) begin
      @(negedge clk);
      check_product('0);
    end
    arst_n = 1'b1;
    // stages still hold reset zeros and then the pair held during reset
    repeat (latency - 1) sb.push_back('0);
    sb.push_back(wide_mul(ops.a, ops.b));
  endtask

  task automatic drain_pipeline();
    while (sb.size() > 0) begin
      @(negedge clk);
      check_product(sb.pop_front());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (timeout_limit > 0 && cycles >= timeout_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      stop_on_fail();
    end
  end

  initial begin
    arst_n        = 1'b1;
    ops.a         = 16'h1234;
    ops.b         = 16'h5678;
    timeout_limit = 0;
    checks        = 0;
    rng           = 32'd12412;
    read_vectors();
    timeout_limit = (vec_a.size() + rand_count + reset_cycles + latency) * 2;
    #1;
    hold_reset(reset_cycles);
    // file pairs then random pairs with a new pair every cycle
    foreach (vec_a[i]) begin
      drive_and_check(vec_a[i], vec_b[i], vec_p[i]);
    end
    for (int i = 0; i < rand_count; i++) begin
      if (i == rand_reset_at) begin
        hold_reset(mid_reset_cycles);
      end
      rng = xorshift32(rng);
      drive_and_check(rng[15:0], rng[31:16], wide_mul(rng[15:0], rng[31:16]));
    end
    drain_pipeline();
    $display("%0d products checked", checks);
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== test/mul_vectors.txt ====
# columns: a  b  a*b, all hex, one operand pair per line
# zero and one operands, corners, then mixed patterns
0000 0000 00000000
0000 ABCD 00000000
1234 0000 00000000
0001 ABCD 0000ABCD
BEEF 0001 0000BEEF
FFFF FFFF FFFE0001
FFFF 0001 0000FFFF
0002 8000 00010000
8000 8000 40000000
00FF 00FF 0000FE01
0100 0100 00010000
1234 5678 06260060
FFFF 0002 0001FFFE
AAAA 5555 38E31C72
00FF FF00 00FE0100
7FFF 7FFF 3FFF0001
8000 FFFF 7FFF8000
0003 0005 0000000F
FFFF 8001 80007FFF
0010 0010 00000100

// ==== list.f ====
src/wallace_pkg.sv
src/partial_product_gen.sv
src/csa_layer.sv
src/csa_reduce_stage.sv
src/final_adder_stage.sv
src/wallace_mul_top.sv
test/clk_gen.sv
test/wallace_mul_sva.sv
test/tb_wallace_mul.sv

// ==== Makefile ====
TOP := tb_wallace_mul
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
